// ==== Makefile ====
# Verilator build and run for the range hood controller

VERILATOR ?= verilator
TOP       ?= hood_top_tb
FILELIST  ?= hood_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hood_top.f ====
source/hood_pkg.sv
source/second_tick.sv
source/bcd_countdown.sv
source/clock_keeper.sv
source/hood_fsm.sv
source/hood_top.sv
test/hood_top_props.sv
test/hood_top_tb.sv

// ==== source/bcd_countdown.sv ====
`timescale 1ns/1ns

module bcd_countdown #(
    parameter type    count_t     = logic [7:0],
    parameter count_t start_value = '0
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   tick,
    input  logic   load,
    input  logic   run,
    output count_t count
);

    localparam int digits = $bits(count_t) / 4;

    // one BCD step down, borrow ripples up
    function automatic count_t bcd_dec(input count_t c);
        count_t r;
        logic   borrow;
        r = c;
        borrow = 1'b1;
        for (int i = 0; i < digits; i++) begin
            if (borrow) begin
                if (r[4*i +: 4] == 4'd0) begin
                    r[4*i +: 4] = 4'd9;
                end else begin
                    r[4*i +: 4] = r[4*i +: 4] - 4'd1;
                    borrow = 1'b0;
                end
            end
        end
        return r;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            count <= '0;
        else if (load)
            count <= start_value;
        else if (!run)
            count <= '0; // idle timer reads zero
        else if (tick && count != '0)
            count <= bcd_dec(count);
    end

endmodule

// ==== source/clock_keeper.sv ====
`timescale 1ns/1ns

module clock_keeper import hood_pkg::*; #(
    parameter bcd_time_t remind_time = REMIND_TIME
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      power,
    input  logic      tick,
    input  logic      run_work,
    input  logic      clear_work,
    input  logic      load_now,
    input  bcd_time_t edit_time,
    output bcd_time_t now_time,
    output bcd_time_t work_time,
    output logic      reminder
);

    // time of day
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            now_time <= '0;
        end else if (!power) begin
            now_time <= '0;
        end else if (load_now) begin
            now_time <= edit_time; // edited value wins over a tick in the same cycle
        end else if (tick) begin
            now_time <= bcd_time_inc(now_time, 1'b1);
        end
    end

    // fan running time, no day wrap
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            work_time <= '0;
        end else if (!power) begin
            work_time <= '0;
        end else if (clear_work) begin
            work_time <= '0;
        end else if (tick && run_work) begin
            work_time <= bcd_time_inc(work_time, 1'b0);
        end
    end

    // BCD keeps numeric order so a plain compare works
    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            reminder <= 1'b0;
        else
            reminder <= power && (work_time >= remind_time);
    end

endmodule

// ==== source/hood_fsm.sv ====
`timescale 1ns/1ns

module hood_fsm import hood_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         power,
    input  logic         key_a,
    input  logic         key_s,
    input  logic         key_w,
    input  logic         key_x,
    input  logic         key_d,
    input  bcd_time_t    now_time,
    input  bcd_time_t    work_time,
    input  storm_count_t storm_count,
    input  clean_count_t clean_count,
    output logic         storm_load,
    output logic         storm_run,
    output logic         clean_load,
    output logic         clean_run,
    output logic         run_work,
    output logic         clear_work,
    output logic         load_now,
    output bcd_time_t    edit_time,
    output hood_mode_t   mode,
    output show_code_t   display_code,
    output bcd_time_t    display_value
);

    hood_mode_t mode_nxt;
    bcd_time_t  edit_nxt;
    logic       storm_used; // storm allowed once per power-on

    always_comb begin
        mode_nxt   = mode;
        edit_nxt   = edit_time;
        storm_load = 1'b0;
        clean_load = 1'b0;
        clear_work = 1'b0;
        load_now   = 1'b0;
        if (!power) begin
            mode_nxt = SHUTDOWN;
        end else begin
            case (mode)
                SHUTDOWN: mode_nxt = STANDBY;
                STANDBY: begin
                    if (key_w) begin
                        mode_nxt = MENU;
                    end else if (key_x) begin
                        mode_nxt = SHOW_WORK;
                    end else if (key_a) begin
                        mode_nxt = SET_HOUR;
                        edit_nxt = now_time; // start editing from the live clock
                    end
                end
                MENU: begin
                    if (key_a) begin
                        mode_nxt = SPEED_ONE;
                    end else if (key_s) begin
                        mode_nxt = SPEED_TWO;
                    end else if (key_d && !storm_used) begin
                        mode_nxt   = STORM;
                        storm_load = 1'b1;
                    end else if (key_x) begin
                        mode_nxt   = CLEAN;
                        clean_load = 1'b1;
                    end else if (key_w) begin
                        mode_nxt = STANDBY;
                    end
                end
                SPEED_ONE: begin
                    if (key_s)
                        mode_nxt = SPEED_TWO;
                    else if (key_w)
                        mode_nxt = STANDBY;
                end
                SPEED_TWO: begin
                    if (key_a)
                        mode_nxt = SPEED_ONE;
                    else if (key_w)
                        mode_nxt = STANDBY;
                end
                STORM: begin
                    if (key_w) begin
                        mode_nxt   = STORM_EXIT;
                        storm_load = 1'b1; // exit run-down starts from a full count
                    end else if (storm_count == '0) begin
                        mode_nxt = SPEED_TWO;
                    end
                end
                STORM_EXIT: begin
                    if (storm_count == '0)
                        mode_nxt = STANDBY;
                end
                CLEAN: begin
                    if (clean_count == '0) begin
                        mode_nxt   = STANDBY;
                        clear_work = 1'b1;
                    end
                end
                SHOW_WORK: begin
                    if (key_w)
                        mode_nxt = STANDBY;
                end
                SET_HOUR: begin
                    if (key_a || key_d)
                        edit_nxt[23:16] = bcd_field_step(edit_time[23:16], key_a, HOUR_MAX);
                    else if (key_s)
                        mode_nxt = SET_MIN;
                end
                SET_MIN: begin
                    if (key_a || key_d)
                        edit_nxt[15:8] = bcd_field_step(edit_time[15:8], key_a, MIN_SEC_MAX);
                    else if (key_s)
                        mode_nxt = SET_SEC;
                end
                SET_SEC: begin
                    if (key_a || key_d) begin
                        edit_nxt[7:0] = bcd_field_step(edit_time[7:0], key_a, MIN_SEC_MAX);
                    end else if (key_s) begin
                        mode_nxt = STANDBY;
                        load_now = 1'b1;
                    end
                end
                default: mode_nxt = SHUTDOWN;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mode       <= SHUTDOWN;
            storm_used <= 1'b0;
        end else begin
            mode <= mode_nxt;
            if (mode_nxt == SHUTDOWN)
                storm_used <= 1'b0;
            else if (mode_nxt == STORM)
                storm_used <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            edit_time <= '0;
        else
            edit_time <= edit_nxt;
    end

    assign storm_run = (mode == STORM) || (mode == STORM_EXIT);
    assign clean_run = (mode == CLEAN);
    assign run_work  = (mode == SPEED_ONE) || (mode == SPEED_TWO) || storm_run;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            display_code  <= SHOW_STAN;
            display_value <= '0;
        end else begin
            display_value <= now_time;
            case (mode)
                MENU:      display_code <= SHOW_MENU;
                SPEED_ONE: display_code <= SHOW_ONE;
                SPEED_TWO: display_code <= SHOW_TWO;
                STORM, STORM_EXIT: begin
                    display_code  <= (mode == STORM) ? SHOW_STORM : SHOW_EXIT;
                    display_value <= {16'h0000, storm_count};
                end
                CLEAN: begin
                    display_code  <= SHOW_CLEAN;
                    display_value <= {12'h000, clean_count};
                end
                SHOW_WORK: begin
                    display_code  <= SHOW_WORKTIME;
                    display_value <= work_time;
                end
                SET_HOUR, SET_MIN, SET_SEC: begin
                    display_value <= edit_time;
                    if (mode == SET_HOUR)
                        display_code <= SHOW_SET_H;
                    else if (mode == SET_MIN)
                        display_code <= SHOW_SET_M;
                    else
                        display_code <= SHOW_SET_S;
                end
                default:   display_code <= SHOW_STAN; // shutdown and standby
            endcase
        end
    end

endmodule

// ==== source/hood_pkg.sv ====
package hood_pkg;

    typedef logic [23:0] bcd_time_t; // hh:mm:ss, one BCD digit per nibble
    typedef logic [7:0]  storm_count_t;
    typedef logic [11:0] clean_count_t;
    typedef logic [7:0]  show_code_t;

    typedef enum logic [3:0] {
        SHUTDOWN,
        STANDBY,
        MENU,
        SPEED_ONE,
        SPEED_TWO,
        STORM,
        STORM_EXIT,
        CLEAN,
        SHOW_WORK,
        SET_HOUR,
        SET_MIN,
        SET_SEC
    } hood_mode_t;

    // screen codes, upper nibble groups the screens
    localparam show_code_t SHOW_STAN     = 8'h01;
    localparam show_code_t SHOW_MENU     = 8'h02;
    localparam show_code_t SHOW_ONE      = 8'h11;
    localparam show_code_t SHOW_TWO      = 8'h12;
    localparam show_code_t SHOW_STORM    = 8'h13;
    localparam show_code_t SHOW_EXIT     = 8'h14;
    localparam show_code_t SHOW_CLEAN    = 8'h15;
    localparam show_code_t SHOW_WORKTIME = 8'h21; // SHOW_WORK is taken by the mode
    localparam show_code_t SHOW_SET_H    = 8'h31;
    localparam show_code_t SHOW_SET_M    = 8'h32;
    localparam show_code_t SHOW_SET_S    = 8'h33;

    localparam storm_count_t STORM_SECONDS = 8'h60;
    localparam clean_count_t CLEAN_SECONDS = 12'h180;
    localparam int           TICKS_PER_SEC = 100_000_000;
    localparam bcd_time_t    REMIND_TIME   = 24'h10_00_00;
    localparam logic [7:0]   HOUR_MAX      = 8'h23;
    localparam logic [7:0]   MIN_SEC_MAX   = 8'h59;

    // one second forward; hours run on to 99 unless wrap_day is set
    function automatic bcd_time_t bcd_time_inc(input bcd_time_t t, input logic wrap_day);
        bcd_time_t  r;
        logic       carry;
        logic [3:0] lim;
        r = t;
        carry = 1'b1;
        for (int i = 0; i < 6; i++) begin
            lim = (i == 1 || i == 3) ? 4'd5 : 4'd9; // tens of sec and min stop at 5
            if (carry) begin
                if (r[4*i +: 4] == lim) begin
                    r[4*i +: 4] = 4'd0;
                end else begin
                    r[4*i +: 4] = r[4*i +: 4] + 4'd1;
                    carry = 1'b0;
                end
            end
        end
        if (wrap_day && r[23:16] > HOUR_MAX)
            r[23:16] = 8'h00;
        return r;
    endfunction

    // two-digit field up or down, wraps between 00 and max
    function automatic logic [7:0] bcd_field_step(input logic [7:0] f, input logic up,
                                                  input logic [7:0] max);
        logic [7:0] r;
        if (up) begin
            if (f == max)
                r = 8'h00;
            else if (f[3:0] == 4'd9)
                r = {f[7:4] + 4'd1, 4'd0};
            else
                r = {f[7:4], f[3:0] + 4'd1};
        end else begin
            if (f == 8'h00)
                r = max;
            else if (f[3:0] == 4'd0)
                r = {f[7:4] - 4'd1, 4'd9};
            else
                r = {f[7:4], f[3:0] - 4'd1};
        end
        return r;
    endfunction

endpackage

// ==== source/hood_top.sv ====
`timescale 1ns/1ns

module hood_top import hood_pkg::*; #(
    parameter int        tick_div    = TICKS_PER_SEC,
    parameter bcd_time_t remind_time = REMIND_TIME
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       power,
    input  logic       key_a,
    input  logic       key_s,
    input  logic       key_w,
    input  logic       key_x,
    input  logic       key_d,
    output hood_mode_t mode,
    output show_code_t display_code,
    output bcd_time_t  display_value,
    output logic       reminder
);

    logic         tick;
    logic         run_work;
    logic         clear_work;
    logic         load_now;
    logic         storm_load;
    logic         storm_run;
    logic         clean_load;
    logic         clean_run;
    bcd_time_t    edit_time;
    bcd_time_t    now_time;
    bcd_time_t    work_time;
    storm_count_t storm_count;
    clean_count_t clean_count;

    second_tick #(
        .tick_div (tick_div)
    ) u_second_tick (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    clock_keeper #(
        .remind_time (remind_time)
    ) u_clock_keeper (
        .clk        (clk),
        .rst        (rst),
        .power      (power),
        .tick       (tick),
        .run_work   (run_work),
        .clear_work (clear_work),
        .load_now   (load_now),
        .edit_time  (edit_time),
        .now_time   (now_time),
        .work_time  (work_time),
        .reminder   (reminder)
    );

    // 60 s storm and exit run-down
    bcd_countdown #(
        .count_t     (storm_count_t),
        .start_value (STORM_SECONDS)
    ) u_storm_timer (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .load  (storm_load),
        .run   (storm_run),
        .count (storm_count)
    );

    bcd_countdown #(
        .count_t     (clean_count_t),
        .start_value (CLEAN_SECONDS)
    ) u_clean_timer (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .load  (clean_load),
        .run   (clean_run),
        .count (clean_count)
    );

    hood_fsm u_hood_fsm (
        .clk           (clk),
        .rst           (rst),
        .power         (power),
        .key_a         (key_a),
        .key_s         (key_s),
        .key_w         (key_w),
        .key_x         (key_x),
        .key_d         (key_d),
        .now_time      (now_time),
        .work_time     (work_time),
        .storm_count   (storm_count),
        .clean_count   (clean_count),
        .storm_load    (storm_load),
        .storm_run     (storm_run),
        .clean_load    (clean_load),
        .clean_run     (clean_run),
        .run_work      (run_work),
        .clear_work    (clear_work),
        .load_now      (load_now),
        .edit_time     (edit_time),
        .mode          (mode),
        .display_code  (display_code),
        .display_value (display_value)
    );

endmodule

// ==== source/second_tick.sv ====
`timescale 1ns/1ns

module second_tick import hood_pkg::*; #(
    parameter int tick_div = TICKS_PER_SEC
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w-1:0] cnt;

    // free running, pulse on terminal count
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == cnt_w'(tick_div - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== test/hood_patterns.txt ====
# op fields: P level | K key | N cycles | C mode code value | R reminder
# value is hhmmss in BCD, an x digit is not checked
P 1
N 35
C STANDBY 01 000003
N 9
C STANDBY 01 000004
R 0
K s
N 2
C STANDBY 01 xxxxxx
K w
N 2
C MENU 02 xxxxxx
K a
N 2
C SPEED_ONE 11 xxxxxx
K a
N 2
C SPEED_ONE 11 xxxxxx
K s
N 2
C SPEED_TWO 12 xxxxxx
K a
N 2
C SPEED_ONE 11 xxxxxx
K w
N 2
C STANDBY 01 xxxxxx
K w
K d
N 1
C STORM 13 000060
N 620
C SPEED_TWO 12 xxxxxx
R 1
K w
K w
K d
N 2
C MENU 02 xxxxxx
K w
P 0
N 3
C SHUTDOWN 01 000000
R 0
P 1
N 3
K w
K d
N 1
C STORM 13 000060
K w
N 1
C STORM_EXIT 14 000060
N 620
C STANDBY 01 xxxxxx
R 1
K x
N 2
C SHOW_WORK 21 xxxxxx
K w
K w
K x
N 1
C CLEAN 15 000180
N 1830
C STANDBY 01 xxxxxx
R 0
K x
N 2
C SHOW_WORK 21 000000
K w
P 0
N 3
P 1
N 3
K a
N 2
C SET_HOUR 31 0000xx
K d
N 2
C SET_HOUR 31 2300xx
K a
K a
N 2
C SET_HOUR 31 0100xx
K s
K d
N 2
C SET_MIN 32 0159xx
K a
N 2
C SET_MIN 32 0100xx
K d
K d
K s
N 2
C SET_SEC 33 0158xx
K a
K s
N 3
C STANDBY 01 0158xx

// ==== test/hood_top_props.sv ====
`timescale 1ns/1ns

module hood_top_props import hood_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       power,
    input hood_mode_t mode,
    input logic       storm_load,
    input logic       clear_work,
    input logic       load_now,
    input bcd_time_t  now_time,
    input bcd_time_t  work_time,
    input bcd_time_t  edit_time
);

    logic storm_started; // storm entered from the menu this power-on

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            storm_started <= 1'b0;
        else if (!power)
            storm_started <= 1'b0;
        else if (storm_load && mode == MENU)
            storm_started <= 1'b1;
    end

    // counters are held at zero too
    power_low_shutdown: assert property (@(posedge clk) disable iff (!rst)
        !power |=> mode == SHUTDOWN && now_time == '0 && work_time == '0)
        else $error("mode is not SHUTDOWN one cycle after power low");

    load_only_in_set_sec: assert property (@(posedge clk) disable iff (!rst)
        load_now |-> mode == SET_SEC ##1 now_time == $past(edit_time))
        else $error("load_now outside SET_SEC or clock not loaded");

    clear_only_in_clean: assert property (@(posedge clk) disable iff (!rst)
        clear_work |-> mode == CLEAN ##1 work_time == '0)
        else $error("clear_work outside CLEAN or work time not cleared");

    // exit reload is allowed but a second storm start is not
    one_storm_per_power_on: assert property (@(posedge clk) disable iff (!rst)
        (storm_load && mode == MENU) |-> !storm_started)
        else $error("storm started twice in one power-on");

endmodule

bind hood_fsm hood_top_props u_hood_top_props (
    .clk        (clk),
    .rst        (rst),
    .power      (power),
    .mode       (mode),
    .storm_load (storm_load),
    .clear_work (clear_work),
    .load_now   (load_now),
    .now_time   (now_time),
    .work_time  (work_time),
    .edit_time  (edit_time)
);

// ==== test/hood_top_tb.sv ====
`timescale 1ns/1ns

module hood_top_tb import hood_pkg::*; ();

    localparam string pattern_file = "test/hood_patterns.txt";
    localparam int    reset_cycles = 10;

    logic       clk = 1'b0;
    logic       rst;
    logic       power;
    logic       key_a;
    logic       key_s;
    logic       key_w;
    logic       key_x;
    logic       key_d;
    hood_mode_t mode;
    show_code_t display_code;
    bcd_time_t  display_value;
    logic       reminder;

    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         cycle_limit = 0;
    logic [7:0] lfsr_state;

    hood_top #(
        .tick_div    (10),
        .remind_time (24'h00_00_20)
    ) u_hood_top (
        .clk           (clk),
        .rst           (rst),
        .power         (power),
        .key_a         (key_a),
        .key_s         (key_s),
        .key_w         (key_w),
        .key_x         (key_x),
        .key_d         (key_d),
        .mode          (mode),
        .display_code  (display_code),
        .display_value (display_value),
        .reminder      (reminder)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic check_mode(input string name, input hood_mode_t exp, input hood_mode_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s mode expected %s actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_code(input string name, input show_code_t exp, input show_code_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s code expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_value(input string name, input bcd_time_t exp, input bcd_time_t mask,
                               input bcd_time_t act);
        checks++;
        if ((act & mask) !== (exp & mask)) begin
            errors++;
            $display("ERR %s value expected %h (mask %h) actual %h", name, exp, mask, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s reminder expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic note_bad_line(input string name, input string what);
        errors++;
        $display("%s: %s", name, what);
    endtask

    function automatic int find_mode(input string s, output hood_mode_t m);
        hood_mode_t t;
        t = t.first();
        m = SHUTDOWN;
        for (int i = 0; i < t.num(); i++) begin
            if (t.name() == s) begin
                m = t;
                return 1;
            end
            t = t.next();
        end
        return 0;
    endfunction

    // six digits where x means any
    function automatic int parse_value(input string s, output bcd_time_t v,
                                       output bcd_time_t mask);
        byte c;
        v = '0;
        mask = '0;
        if (s.len() != 6)
            return 0;
        for (int i = 0; i < 6; i++) begin
            c = s[i];
            v = v << 4;
            mask = mask << 4;
            if (c >= "0" && c <= "9") begin
                v[3:0] = 4'(c - "0");
                mask[3:0] = 4'hf;
            end else if (c != "x") begin
                return 0;
            end
        end
        return 1;
    endfunction

    task automatic press_key(input string k, output logic ok);
        int gap;
        take_bits(2, gap);
        repeat (gap + 1) @(posedge clk); // 1 to 4 idle cycles
        ok = 1'b1;
        case (k)
            "a": key_a <= 1'b1;
            "s": key_s <= 1'b1;
            "w": key_w <= 1'b1;
            "x": key_x <= 1'b1;
            "d": key_d <= 1'b1;
            default: ok = 1'b0;
        endcase
        @(posedge clk);
        key_a <= 1'b0;
        key_s <= 1'b0;
        key_w <= 1'b0;
        key_x <= 1'b0;
        key_d <= 1'b0;
    endtask

    // waits plus worst case key gaps
    task automatic count_cycles(output int limit);
        int    fd;
        int    n;
        int    got;
        string line;
        string op;
        limit = reset_cycles + 200;
        fd = $fopen(pattern_file, "r");
        if (fd == 0)
            return;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            got = $sscanf(line, "%s %d", op, n);
            if (got < 1 || op[0] == "#")
                continue;
            if (op == "N" && got == 2)
                limit += n;
            else if (op == "K")
                limit += 6;
            else
                limit += 2;
        end
        $fclose(fd);
    endtask

    initial begin
        int         fd;
        int         line_no;
        int         n;
        string      line;
        string      op;
        string      name;
        string      f1;
        string      f2;
        hood_mode_t exp_mode;
        show_code_t exp_code;
        bcd_time_t  exp_value;
        bcd_time_t  exp_mask;
        logic       ok;

        rst = 1'b0;
        power = 1'b0;
        key_a = 1'b0;
        key_s = 1'b0;
        key_w = 1'b0;
        key_x = 1'b0;
        key_d = 1'b0;
        lfsr_state = 8'd86;
        count_cycles(cycle_limit);
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;

        @(negedge clk);
        check_mode("after reset", SHUTDOWN, mode);
        check_flag("after reset", 1'b0, reminder);

        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            note_bad_line(pattern_file, "the pattern file cannot be opened");
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                if ($sscanf(line, "%s", op) != 1 || op[0] == "#")
                    continue;
                name = $sformatf("line %0d", line_no);
                case (op)
                    "P": begin
                        if ($sscanf(line, "%s %d", op, n) == 2) begin
                            @(posedge clk);
                            power <= n[0];
                        end else begin
                            note_bad_line(name, "power command has no level");
                        end
                    end
                    "K": begin
                        if ($sscanf(line, "%s %s", op, f1) == 2)
                            press_key(f1, ok);
                        else
                            ok = 1'b0;
                        if (!ok)
                            note_bad_line(name, "key command names no known key");
                    end
                    "N": begin
                        if ($sscanf(line, "%s %d", op, n) == 2)
                            repeat (n) @(posedge clk);
                        else
                            note_bad_line(name, "idle command has no cycle count");
                    end
                    "C": begin
                        if ($sscanf(line, "%s %s %h %s", op, f1, exp_code, f2) != 4 ||
                            find_mode(f1, exp_mode) == 0 ||
                            parse_value(f2, exp_value, exp_mask) == 0) begin
                            note_bad_line(name, "check command cannot be read");
                        end else begin
                            @(negedge clk); // outputs settled
                            check_mode(name, exp_mode, mode);
                            check_code(name, exp_code, display_code);
                            check_value(name, exp_value, exp_mask, display_value);
                        end
                    end
                    "R": begin
                        if ($sscanf(line, "%s %d", op, n) == 2) begin
                            @(negedge clk);
                            check_flag(name, n[0], reminder);
                        end else begin
                            note_bad_line(name, "reminder check has no level");
                        end
                    end
                    default: note_bad_line(name, "unknown command in the pattern file");
                endcase
            end
            $fclose(fd);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
